/* design/i2s_in_pkg.sv */
package i2s_in_pkg;

    // Audio word and FIFO sizing
    localparam int SAMPLE_W = 16;                 // Bits per channel word
    localparam int FIFO_AW  = 3;                  // Depth of 8 entries

    // Self-test ramp
    localparam int BIST_VAL_W  = 12;              // Ramp value width
    localparam int BIST_INC_W  = 8;               // Ramp step width
    localparam int BIST_PERIOD = 64;              // Clock cycles per ramp sample

    // One stereo frame as it travels through the FIFO
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;                // Channel sent with ws low
        logic [SAMPLE_W-1:0] right;               // Channel sent with ws high
    } stereo_sample_t;

    // Ramp generator setup, held static while the ramp runs
    typedef struct packed {
        logic [BIST_VAL_W-1:0] start_val;         // First and wrap value
        logic [BIST_VAL_W-1:0] up_limit;          // Highest value before wrap
        logic [BIST_INC_W-1:0] inc;               // Step added per sample
    } bist_cfg_t;

    // Serial port pin bundle, raw or synchronized
    typedef struct packed {
        logic sck;                                // Bit clock
        logic ws;                                 // Word select
        logic sd;                                 // Serial data
    } i2s_pins_t;

endpackage

/* design/i2s_sync.sv */
`timescale 1ns/100ps

module i2s_sync
    import i2s_in_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  i2s_pins_t pins_raw,
    output i2s_pins_t pins,
    output logic      sck_rise
);

    i2s_pins_t meta;                              // First stage, may go metastable
    logic      sck_d;                             // Synchronized sck one cycle back

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            meta  <= '0;
            pins  <= '0;
            sck_d <= 1'b0;
        end
        else
        begin
            meta  <= pins_raw;
            pins  <= meta;
            sck_d <= pins.sck;
        end
    end

    // High in the first cycle the synchronized bit clock reads 1
    assign sck_rise = pins.sck & ~sck_d;

    // The bit clock runs far slower than clk, so rises are at least four cycles apart
    a_sck_rise_single: assert property (
        @(posedge clk) disable iff (!rst)
        sck_rise |-> !$past(sck_rise, 2) && !$past(sck_rise, 3)
    );

endmodule

/* design/i2s_deserializer.sv */
`timescale 1ns/100ps

module i2s_deserializer
    import i2s_in_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  i2s_pins_t      pins,
    input  logic           sck_rise,
    input  logic           en,
    output stereo_sample_t sample,
    output logic           valid
);

    typedef enum logic [1:0] {
        IDLE,                                     // Waiting for en and a ws fall
        WAIT_LEFT,                                // Collecting the first left word
        RUN                                       // Full frames flowing
    } state_t;

    state_t              state;
    logic [SAMPLE_W-1:0] shreg;                   // MSB-first shift register
    logic [SAMPLE_W-1:0] left_hold;               // Last complete left word
    logic [SAMPLE_W-1:0] word;                    // Word closed by the current bit
    logic                ws_prev;                 // ws at the previous bit clock edge
    logic                ws_edge;
    logic                active;
    logic                left_done;
    logic                right_done;

    // The bit sampled on a ws change is the LSB of the word just ended
    assign word       = {shreg[SAMPLE_W-2:0], pins.sd};
    assign ws_edge    = ws_prev != pins.ws;
    assign active     = sck_rise && en && (state != IDLE);
    assign left_done  = active && ws_edge && !ws_prev;
    assign right_done = active && ws_edge && ws_prev && (state == RUN);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state   <= IDLE;
            ws_prev <= 1'b0;
            valid   <= 1'b0;
        end
        else
        begin
            valid <= right_done;                  // One cycle after the closing edge
            if (sck_rise)
                ws_prev <= pins.ws;               // Tracked even while idle
            if (!en)
                state <= IDLE;
            else if (sck_rise)
            begin
                case (state)
                    IDLE:      if (ws_prev && !pins.ws) state <= WAIT_LEFT;
                    WAIT_LEFT: if (left_done) state <= RUN;
                    default:   state <= RUN;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise && en)
            shreg <= word;
        if (left_done)
            left_hold <= word;
        if (right_done)
        begin
            sample.left  <= left_hold;
            sample.right <= word;
        end
    end

    // A frame is only complete after a left word was captured since start
    a_valid_not_idle: assert property (
        @(posedge clk) disable iff (!rst)
        valid |-> (state != IDLE)
    );

endmodule

/* design/i2s_bist_gen.sv */
`timescale 1ns/100ps

module i2s_bist_gen
    import i2s_in_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           bist_en,
    input  bist_cfg_t      cfg,
    output stereo_sample_t sample,
    output logic           valid
);

    logic [$clog2(BIST_PERIOD)-1:0] cnt;          // Pacing counter
    logic [BIST_VAL_W-1:0]          value;        // Current ramp value
    logic [BIST_VAL_W:0]            sum;          // One spare bit for the carry
    logic                           tick;

    assign tick = bist_en && (cnt == BIST_PERIOD - 1);
    assign sum  = {1'b0, value} + {{(BIST_VAL_W + 1 - BIST_INC_W){1'b0}}, cfg.inc};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cnt   <= '0;
            value <= '0;
            valid <= 1'b0;
        end
        else if (!bist_en)
        begin
            cnt   <= '0;
            value <= cfg.start_val;               // Ramp restarts on every enable
            valid <= 1'b0;
        end
        else
        begin
            valid <= tick;
            if (tick)
            begin
                cnt <= '0;
                if (sum > {1'b0, cfg.up_limit})
                    value <= cfg.start_val;       // Wrap past the limit
                else
                    value <= sum[BIST_VAL_W-1:0];
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    // Same value on both channels, low bits zero
    always_ff @(posedge clk)
    begin
        if (tick)
        begin
            sample.left  <= {value, {(SAMPLE_W - BIST_VAL_W){1'b0}}};
            sample.right <= {value, {(SAMPLE_W - BIST_VAL_W){1'b0}}};
        end
    end

    // A pulse after the ramp is disabled would be lost in the source mux
    a_valid_when_enabled: assert property (
        @(posedge clk) disable iff (!rst)
        valid |-> bist_en
    );

endmodule

/* design/sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo
    import i2s_in_pkg::*;
#(
    parameter type entry_t = stereo_sample_t
)
(
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t push_data,
    output logic   drop,
    output entry_t out_data,
    output logic   rts,
    input  logic   rtr
);

    entry_t             mem [0:(1 << FIFO_AW) - 1];
    logic [FIFO_AW:0]   wr_ptr;                   // Extra MSB tells full from empty
    logic [FIFO_AW:0]   rd_ptr;
    logic [FIFO_AW:0]   fill;                     // Entries currently stored
    logic               full;
    logic               pop;
    logic               push_ok;

    assign fill     = wr_ptr - rd_ptr;
    assign full     = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                      (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign rts      = (wr_ptr != rd_ptr);
    assign pop      = rts && rtr;
    assign push_ok  = push && (!full || pop);     // Pop frees the slot this edge
    assign out_data = mem[rd_ptr[FIFO_AW-1:0]];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            drop   <= 1'b0;
        end
        else
        begin
            drop <= push && !push_ok;             // Stored entries are kept
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // On a full FIFO the write slot is the head, which is read out the same cycle
    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
    end

    a_fill_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        fill <= (FIFO_AW + 1)'(1 << FIFO_AW)
    );

endmodule

/* design/i2s_in.sv */
`timescale 1ns/100ps

module i2s_in
    import i2s_in_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  i2s_pins_t      pins_raw,
    input  logic           en,
    input  logic           bist_en,
    input  bist_cfg_t      bist_cfg,
    input  logic           overrun_clr,
    output stereo_sample_t out_data,
    output logic           rts,
    input  logic           rtr,
    output logic           fifo_overrun
);

    i2s_pins_t      pins;                         // Pins in the clk domain
    logic           sck_rise;
    stereo_sample_t rx_sample;
    logic           rx_valid;
    stereo_sample_t bist_sample;
    logic           bist_valid;
    stereo_sample_t push_data;
    logic           push;
    logic           drop;

    i2s_sync u_sync (
        .clk      (clk),
        .rst      (rst),
        .pins_raw (pins_raw),
        .pins     (pins),
        .sck_rise (sck_rise)
    );

    i2s_deserializer u_deser (
        .clk      (clk),
        .rst      (rst),
        .pins     (pins),
        .sck_rise (sck_rise),
        .en       (en),
        .sample   (rx_sample),
        .valid    (rx_valid)
    );

    i2s_bist_gen u_bist (
        .clk      (clk),
        .rst      (rst),
        .bist_en  (bist_en),
        .cfg      (bist_cfg),
        .sample   (bist_sample),
        .valid    (bist_valid)
    );

    // Test ramp replaces received audio
    assign push_data = bist_en ? bist_sample : rx_sample;
    assign push      = bist_en ? bist_valid  : rx_valid;

    sample_fifo #(.entry_t(stereo_sample_t)) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .drop      (drop),
        .out_data  (out_data),
        .rts       (rts),
        .rtr       (rtr)
    );

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            fifo_overrun <= 1'b0;
        else if (drop)
            fifo_overrun <= 1'b1;                 // Set wins over clear
        else if (overrun_clr)
            fifo_overrun <= 1'b0;
    end

endmodule

/* verification/i2s_in_checker.sv */
`timescale 1ns/100ps

module i2s_in_checker
    import i2s_in_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  stereo_sample_t out_data,
    input  logic           rts,
    input  logic           rtr,
    input  logic           fifo_overrun
);

    stereo_sample_t exp_q [$];                    // Samples the DUT must still deliver
    stereo_sample_t exp_head;
    int             errors = 0;
    string          test_name = "none";

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic expect_sample(input stereo_sample_t s);
        exp_q.push_back(s);
    endtask

    // Ramp model, add inc and fall back to start_val past the limit
    task automatic expect_ramp(input bist_cfg_t cfg, input int n);
        logic [BIST_VAL_W-1:0] v;
        logic [BIST_VAL_W:0]   s;
        stereo_sample_t        smp;
        v = cfg.start_val;
        for (int i = 0; i < n; i++)
        begin
            smp.left  = {v, 4'h0};
            smp.right = {v, 4'h0};
            exp_q.push_back(smp);
            s = {1'b0, v} + {5'b0, cfg.inc};
            if (s > {1'b0, cfg.up_limit})
                v = cfg.start_val;
            else
                v = s[BIST_VAL_W-1:0];
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // Overrun flag against the level the test expects
    task automatic check_overrun(input string what, input logic exp);
        check_value(what, {31'b0, exp}, {31'b0, fifo_overrun});
    endtask

    // A pop happens on every edge with rts and rtr both high
    always @(posedge clk)
    begin
        if (rst && rts && rtr)
        begin
            if (exp_q.size() == 0)
            begin
                $display("%s: the DUT delivered sample %h when none was expected",
                         test_name, out_data);
                errors++;
            end
            else
            begin
                exp_head = exp_q.pop_front();
                check_value("sample", exp_head, out_data);
            end
        end
    end

endmodule

/* verification/i2s_in_tb.sv */
`timescale 1ns/100ps

module i2s_in_tb
    import i2s_in_pkg::*;
;

    logic           clk = 1'b0;
    logic           rst = 1'b0;
    i2s_pins_t      pins_raw = '0;
    logic           en = 1'b0;
    logic           bist_en = 1'b0;
    bist_cfg_t      bist_cfg = '0;
    logic           overrun_clr = 1'b0;
    logic           rtr = 1'b0;
    stereo_sample_t out_data;
    logic           rts;
    logic           fifo_overrun;

    integer         seed = 83;
    int             tests_run = 0;
    int             tests_bad = 0;
    int             err_start = 0;

    always #2 clk = ~clk;                         // 4 ns period

    i2s_in dut (
        .clk          (clk),
        .rst          (rst),
        .pins_raw     (pins_raw),
        .en           (en),
        .bist_en      (bist_en),
        .bist_cfg     (bist_cfg),
        .overrun_clr  (overrun_clr),
        .out_data     (out_data),
        .rts          (rts),
        .rtr          (rtr),
        .fifo_overrun (fifo_overrun)
    );

    i2s_in_checker chk (
        .clk          (clk),
        .rst          (rst),
        .out_data     (out_data),
        .rts          (rts),
        .rtr          (rtr),
        .fifo_overrun (fifo_overrun)
    );

    task automatic abort_run(input string msg);
        $display("Timeout in %s: %s", chk.test_name, msg);
        $display("test failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        chk.test_name = name;
        err_start = chk.errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (chk.errors == err_start)
            $display("PASS %s", chk.test_name);
        else
        begin
            $display("FAIL %s with %0d errors", chk.test_name, chk.errors - err_start);
            tests_bad++;
        end
    endtask

    // One bit slot, data changes while sck is low, sampled on the rise
    task automatic send_bit(input logic ws, input logic sd);
        @(posedge clk);
        pins_raw.sck <= 1'b0;
        pins_raw.ws  <= ws;
        pins_raw.sd  <= sd;
        repeat (8) @(posedge clk);
        pins_raw.sck <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    // ws leads the data by one slot, so each frame ends with the right LSB on ws low
    task automatic send_frames(input int n, input int first_expected);
        logic [31:0]    r;
        stereo_sample_t f;
        for (int k = 0; k < n; k++)
        begin
            r = $random(seed);
            f.left  = r[15:0];
            r = $random(seed);
            f.right = r[15:0];
            if (k >= first_expected)
                chk.expect_sample(f);
            for (int b = SAMPLE_W - 1; b >= 1; b--)
                send_bit(1'b0, f.left[b]);
            send_bit(1'b1, f.left[0]);
            for (int b = SAMPLE_W - 1; b >= 1; b--)
                send_bit(1'b1, f.right[b]);
            send_bit(1'b0, f.right[0]);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (chk.pending() != 0 || rts)
        begin
            @(posedge clk);
            n++;
            if (n > limit)
                abort_run("expected samples never came out of the FIFO");
        end
    endtask

    task automatic random_cfg();
        logic [31:0] r;
        r = $random(seed);
        bist_cfg.start_val <= r[11:0];
        bist_cfg.up_limit  <= r[23:12];
        bist_cfg.inc       <= (r[31:24] == 8'h00) ? 8'h01 : r[31:24];
    endtask

    initial
    begin
        int n;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        start_test("reception");
        en  <= 1'b1;
        rtr <= 1'b1;
        send_frames(21, 1);                       // First frame has no ws fall before it
        wait_drain(200);
        finish_test();

        start_test("enable_start");
        en <= 1'b0;
        send_frames(3, 3);
        @(posedge clk);
        en <= 1'b1;
        send_frames(4, 1);
        wait_drain(200);
        finish_test();

        start_test("bist_ramp");
        en <= 1'b0;
        random_cfg();
        @(posedge clk);
        chk.expect_ramp(bist_cfg, 30);
        bist_en <= 1'b1;
        n = 0;
        while (chk.pending() != 0)
        begin
            @(posedge clk);
            n++;
            if (n > 31 * BIST_PERIOD + 20)
                abort_run("ramp samples stopped arriving");
        end
        bist_en <= 1'b0;
        wait_drain(20);
        finish_test();

        start_test("back_pressure");
        rtr <= 1'b0;
        random_cfg();
        @(posedge clk);
        chk.expect_ramp(bist_cfg, 1 << FIFO_AW);
        bist_en <= 1'b1;
        n = 0;
        while (!rts)
        begin
            @(posedge clk);
            n++;
            if (n > BIST_PERIOD + 10)
                abort_run("rts never rose");
        end
        n = 0;
        while (!fifo_overrun)
        begin
            @(posedge clk);
            n++;
            if (n > 9 * BIST_PERIOD + 10)
                abort_run("fifo_overrun never set");
        end
        // Ninth push drops, then the drop pulse and the flag each take one edge
        chk.check_value("overrun_delay", 8 * BIST_PERIOD + 1, n);
        bist_en <= 1'b0;
        rtr     <= 1'b1;
        wait_drain(40);
        finish_test();

        start_test("overrun_clear");
        chk.check_overrun("overrun_before_clear", 1'b1);
        overrun_clr <= 1'b1;
        @(posedge clk);
        overrun_clr <= 1'b0;
        @(posedge clk);
        chk.check_overrun("overrun_after_clear", 1'b0);
        rtr <= 1'b0;
        random_cfg();
        @(posedge clk);
        chk.expect_ramp(bist_cfg, 1 << FIFO_AW);
        bist_en <= 1'b1;
        // Fill the FIFO up to its depth, no push may be dropped
        for (int i = 0; i < (1 << FIFO_AW) * BIST_PERIOD + 4; i++)
        begin
            @(posedge clk);
            chk.check_overrun("overrun_while_filling", 1'b0);
        end
        bist_en <= 1'b0;
        rtr     <= 1'b1;
        wait_drain(40);
        finish_test();

        $display("Tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, chk.errors);
        if (chk.errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* src.f */
design/i2s_in_pkg.sv
design/i2s_sync.sv
design/i2s_deserializer.sv
design/i2s_bist_gen.sv
design/sample_fifo.sv
design/i2s_in.sv
verification/i2s_in_checker.sv
verification/i2s_in_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the I2S receiver testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module i2s_in_tb \
    -f src.f -o sim_i2s_in > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_i2s_in > sim.log 2>&1
cat sim.log

grep -q "^test passed$" sim.log && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
